// File: sim.f
+incdir+src
src/stripe_pkg.sv
src/stripe_axi_if.sv
src/axi_wr_bank.sv
src/axi_stripe_wr.sv
src/stripe_wr_top.sv
bench/tb_clk_gen.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Bender.yml
package:
  name: stripe_wr

export_include_dirs:
  - src

sources:
  - files:
      - src/stripe_pkg.sv
      - src/stripe_axi_if.sv
      - src/axi_wr_bank.sv
      - src/axi_stripe_wr.sv
      - src/stripe_wr_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_checker.sv
      - bench/tb_top.sv

// File: bench/tb_top.sv
`include "stripe_consts.svh"

module tb_top;

  localparam int NUM_S = `STRIPE_NUM_S;
  // beats 4 + 16 + 24 + 32 + 16 + 12 * 16 and reads 1 + 4 + 6 + 8 + 64
  localparam int TOTAL_BEATS    = 284;
  localparam int TOTAL_READS    = 83;
  localparam int TIMEOUT_CYCLES = (TOTAL_BEATS + TOTAL_READS) * 8 + 4;

  logic                                         clk;
  logic                                         rst_n;
  logic                                         awvalid;
  logic [`STRIPE_ADDR_W-1:0]                    awaddr;
  logic [`STRIPE_ID_W-1:0]                      awid;
  logic [7:0]                                   awlen;
  logic [2:0]                                   awsize;
  logic [1:0]                                   awburst;
  logic                                         awready;
  logic                                         wvalid;
  logic [`STRIPE_DATA_W-1:0]                    wdata;
  logic [`STRIPE_STRB_W-1:0]                    wstrb;
  logic                                         wlast;
  logic                                         wready;
  logic                                         bvalid;
  logic [`STRIPE_ID_W-1:0]                      bid;
  stripe_pkg::stripe_resp_e                     bresp;
  logic                                         bready;
  logic [`STRIPE_BANK_AW-1:0]                   rd_addr;
  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] rd_data;
  logic                                         rd_chk;
  integer                                       seed;
  int                                           cycles;

  tb_clk_gen clk_gen0 (
    .clk  (clk),
    .rst_n(rst_n)
  );

  stripe_wr_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awaddr(awaddr), .awid(awid), .awlen(awlen),
    .awsize(awsize), .awburst(awburst), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
    .bvalid(bvalid), .bid(bid), .bresp(bresp), .bready(bready),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  tb_checker chk0 (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid), .awlen(awlen),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
    .rd_chk(rd_chk), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  // ------------------------------------------------------------------------
  // bus drivers
  // ------------------------------------------------------------------------

  // one full burst from AW to B, with bready held low for up to max_stall
  // cycles once the response shows up
  task automatic write_burst(input logic [`STRIPE_ADDR_W-1:0] addr, input logic [7:0] len,
                             input logic [`STRIPE_ID_W-1:0] id, input bit rand_strb,
                             input int max_stall);
    int stall;
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    awlen   <= len;
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    for (int k = 0; k <= len; k++) begin
      wvalid <= 1'b1;
      wdata  <= $random(seed);
      wstrb  <= rand_strb ? `STRIPE_STRB_W'($random(seed)) : '1;
      wlast  <= (k == len);
      do @(posedge clk); while (!wready);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    if (max_stall > 0) begin
      bready <= 1'b0;
      do @(posedge clk); while (!bvalid);
      stall = {$random(seed)} % max_stall;
      repeat (stall) @(posedge clk);
      bready <= 1'b1;
    end
    do @(posedge clk); while (!bvalid);
  endtask

  task automatic read_back(input int first, input int count);
    for (int a = first; a < first + count; a++) begin
      rd_addr <= `STRIPE_BANK_AW'(a);
      rd_chk  <= 1'b1;
      @(posedge clk);
    end
    rd_chk <= 1'b0;
    // data trails the address by one cycle and is compared one cycle later
    repeat (2) @(posedge clk);
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    int start;
    int stripes;
    seed = 94022;
    awvalid <= 1'b0;
    awaddr  <= '0;
    awid    <= '0;
    awlen   <= '0;
    awsize  <= 3'd2;
    awburst <= 2'b01;
    wvalid  <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b0;
    bready  <= 1'b1;
    rd_addr <= '0;
    rd_chk  <= 1'b0;
    wait (rst_n);
    @(posedge clk);

    write_burst(12'h000, 8'(NUM_S - 1), 4'h1, 1'b0, 0);
    read_back(0, 1);
    chk0.test_done("minimum burst");

    // local words 16 to 19 in every bank
    write_burst(12'h100, 8'd15, 4'h2, 1'b0, 0);
    read_back(16, 4);
    chk0.test_done("multi-stripe burst");

    for (int i = 0; i < 3; i++) begin
      write_burst(12'h200 + 12'(i * 32), 8'd7, `STRIPE_ID_W'($random(seed)), 1'b0, 0);
    end
    read_back(32, 6);
    chk0.test_done("id echo");

    // starts at local word 60 and runs four words past the bank depth
    write_burst(12'h3c0, 8'd31, 4'h5, 1'b0, 0);
    read_back(60, 4);
    read_back(0, 4);
    chk0.test_done("overflow");

    for (int i = 0; i < 2; i++) begin
      write_burst(12'h080 + 12'(i * 32), 8'd7, `STRIPE_ID_W'($random(seed)), 1'b0, 12);
    end
    // the checker looks at the last response on the edge that took it
    @(posedge clk);
    chk0.test_done("response back-pressure");

    for (int i = 0; i < 12; i++) begin
      start   = {$random(seed)} % `STRIPE_BANK_WORDS;
      stripes = {$random(seed)} % 4 + 1;
      write_burst(`STRIPE_ADDR_W'(start * NUM_S * `STRIPE_STRB_W), 8'(stripes * NUM_S - 1),
                  `STRIPE_ID_W'($random(seed)), 1'b1, 4);
    end
    read_back(0, `STRIPE_BANK_WORDS);
    chk0.test_done("random mix");

    chk0.report_counts();
    if (chk0.err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles with a handshake still pending", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

// File: bench/tb_checker.sv
`include "stripe_consts.svh"

// watches the manager and read-back ports of the striper and keeps its own
// image of every bank to compare against
module tb_checker (
  input logic                                         clk,
  input logic                                         rst_n,
  input logic                                         awvalid,
  input logic                                         awready,
  input logic [`STRIPE_ADDR_W-1:0]                    awaddr,
  input logic [`STRIPE_ID_W-1:0]                      awid,
  input logic [7:0]                                   awlen,
  input logic                                         wvalid,
  input logic                                         wready,
  input logic [`STRIPE_DATA_W-1:0]                    wdata,
  input logic [`STRIPE_STRB_W-1:0]                    wstrb,
  input logic                                         bvalid,
  input logic                                         bready,
  input logic [`STRIPE_ID_W-1:0]                      bid,
  input stripe_pkg::stripe_resp_e                     bresp,
  input logic                                         rd_chk,
  input logic [`STRIPE_BANK_AW-1:0]                   rd_addr,
  input logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] rd_data
);

  localparam int NUM_S = `STRIPE_NUM_S;

  // unwritten words start unknown here just as they do in the banks
  logic [`STRIPE_DATA_W-1:0] ref_mem [NUM_S][`STRIPE_BANK_WORDS];
  logic [`STRIPE_ID_W-1:0]   exp_id [$];
  logic [1:0]                exp_resp [$];
  logic [`STRIPE_ID_W-1:0]   id_e;
  logic [1:0]                resp_e;
  logic [`STRIPE_ID_W-1:0]   bid_q;
  logic                      hold_q;
  logic                      busy_q;
  logic                      rd_chk_q;
  logic [`STRIPE_BANK_AW-1:0] rd_addr_q;
  int                        base_word;
  int                        beat;
  int                        err_count;
  int                        check_count;
  int                        test_count;
  int                        test_err_base;

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------

  // the last word of a burst has the highest local word, so it alone decides
  // whether the burst ran past the bank depth
  function automatic logic [1:0] expected_resp(logic [`STRIPE_ADDR_W-1:0] addr,
                                               logic [7:0] len);
    int last_word;
    last_word = addr / `STRIPE_STRB_W + len;
    if (last_word / NUM_S >= `STRIPE_BANK_WORDS) begin
      return `STRIPE_RESP_SLVERR;
    end
    return `STRIPE_RESP_OKAY;
  endfunction

  // manager word w sits in bank w mod NUM_S at local word w / NUM_S
  // a local word at or past the bank depth is lost
  function automatic void store_word(int w, logic [`STRIPE_DATA_W-1:0] data,
                                     logic [`STRIPE_STRB_W-1:0] strb);
    int bank;
    int lw;
    bank = w % NUM_S;
    lw   = w / NUM_S;
    if (lw < `STRIPE_BANK_WORDS) begin
      for (int b = 0; b < `STRIPE_STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[bank][lw][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) begin
        base_word = awaddr / `STRIPE_STRB_W;
        beat      = 0;
        exp_id.push_back(awid);
        exp_resp.push_back(expected_resp(awaddr, awlen));
      end
      if (wvalid && wready) begin
        store_word(base_word + beat, wdata, wstrb);
        beat = beat + 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // comparison
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      hold_q   <= 1'b0;
      busy_q   <= 1'b0;
      rd_chk_q <= 1'b0;
    end else begin
      // a stalled response keeps its valid and id until it is taken
      if (hold_q && (!bvalid || bid !== bid_q)) begin
        $display("MISMATCH %0t: response changed while bready was low", $time);
        err_count++;
      end
      // no new burst may start until the response of the previous one is taken
      if (busy_q && awready) begin
        $display("MISMATCH %0t: awready high before the response was taken", $time);
        err_count++;
      end
      if (bvalid && bready) begin
        if (exp_id.size() == 0) begin
          $display("%0t: a write response came back with no burst outstanding", $time);
          err_count++;
        end else begin
          id_e   = exp_id.pop_front();
          resp_e = exp_resp.pop_front();
          check_count++;
          if (bid !== id_e || bresp !== resp_e) begin
            $display("MISMATCH %0t: bid %0h bresp %0d, expected bid %0h bresp %0d",
                     $time, bid, bresp, id_e, resp_e);
            err_count++;
          end
        end
      end
      // read data answers the address of the previous cycle
      if (rd_chk_q) begin
        for (int b = 0; b < NUM_S; b++) begin
          check_count++;
          if (rd_data[b] !== ref_mem[b][rd_addr_q]) begin
            $display("MISMATCH %0t: bank %0d word %0d read %h, expected %h",
                     $time, b, rd_addr_q, rd_data[b], ref_mem[b][rd_addr_q]);
            err_count++;
          end
        end
      end
      // a burst is outstanding from its address handshake to its response
      if (awvalid && awready) begin
        busy_q <= 1'b1;
      end else if (bvalid && bready) begin
        busy_q <= 1'b0;
      end
      hold_q    <= bvalid && !bready;
      bid_q     <= bid;
      rd_chk_q  <= rd_chk;
      rd_addr_q <= rd_addr;
    end
  end

  task automatic test_done(input string name);
    test_count++;
    $display("test %0d %0s: %0d errors", test_count, name, err_count - test_err_base);
    test_err_base = err_count;
  endtask

  task automatic report_counts();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
  endtask

endmodule

// File: bench/tb_clk_gen.sv
// free running clock with a period of 10 and a reset held low for the
// first four rising edges
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: src/stripe_wr_top.sv
`include "stripe_consts.svh"

// striper with its banks behind plain manager and read-back ports
module stripe_wr_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        awvalid,
  input  logic [`STRIPE_ADDR_W-1:0]                   awaddr,
  input  logic [`STRIPE_ID_W-1:0]                     awid,
  input  logic [7:0]                                  awlen,
  input  logic [2:0]                                  awsize,
  input  logic [1:0]                                  awburst,
  output logic                                        awready,
  input  logic                                        wvalid,
  input  logic [`STRIPE_DATA_W-1:0]                   wdata,
  input  logic [`STRIPE_STRB_W-1:0]                   wstrb,
  input  logic                                        wlast,
  output logic                                        wready,
  output logic                                        bvalid,
  output logic [`STRIPE_ID_W-1:0]                     bid,
  output stripe_pkg::stripe_resp_e                    bresp,
  input  logic                                        bready,
  input  logic [`STRIPE_BANK_AW-1:0]                  rd_addr,
  output logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] rd_data
);

  localparam int NUM_S = `STRIPE_NUM_S;

  // one write link per bank
  stripe_axi_if link [NUM_S] ();

  axi_stripe_wr #(
    .NUM_S(NUM_S)
  ) u_stripe (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_awvalid(awvalid),
    .s_awaddr (awaddr),
    .s_awid   (awid),
    .s_awlen  (awlen),
    .s_awsize (awsize),
    .s_awburst(awburst),
    .s_awready(awready),
    .s_wvalid (wvalid),
    .s_wdata  (wdata),
    .s_wstrb  (wstrb),
    .s_wlast  (wlast),
    .s_wready (wready),
    .s_bvalid (bvalid),
    .s_bid    (bid),
    .s_bresp  (bresp),
    .s_bready (bready),
    .m        (link)
  );

  // every bank reads the same local word so a full stripe comes back at once
  for (genvar i = 0; i < NUM_S; i++) begin : g_bank
    axi_wr_bank u_bank (
      .clk    (clk),
      .rst_n  (rst_n),
      .s      (link[i]),
      .rd_addr(rd_addr),
      .rd_data(rd_data[i])
    );
  end

endmodule

// File: src/axi_stripe_wr.sv
`include "stripe_consts.svh"

// spreads one manager write burst over NUM_S banks word by word
// the manager must send stripe aligned, full width INCR bursts whose
// length covers whole stripes
module axi_stripe_wr #(
  parameter int NUM_S = `STRIPE_NUM_S
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_awvalid,
  input  logic [`STRIPE_ADDR_W-1:0] s_awaddr,
  input  logic [`STRIPE_ID_W-1:0]   s_awid,
  input  logic [7:0]                s_awlen,
  input  logic [2:0]                s_awsize,
  input  logic [1:0]                s_awburst,
  output logic                      s_awready,
  input  logic                      s_wvalid,
  input  logic [`STRIPE_DATA_W-1:0] s_wdata,
  input  logic [`STRIPE_STRB_W-1:0] s_wstrb,
  input  logic                      s_wlast,
  output logic                      s_wready,
  output logic                      s_bvalid,
  output logic [`STRIPE_ID_W-1:0]   s_bid,
  output stripe_pkg::stripe_resp_e  s_bresp,
  input  logic                      s_bready,
  stripe_axi_if.mgr                 m [NUM_S]
);

  localparam int S_W = $clog2(NUM_S);

  stripe_pkg::stripe_addr_u  aw_u;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      b_hs;
  logic [NUM_S-1:0]          aw_valid;
  logic [NUM_S-1:0]          aw_done;
  logic [NUM_S-1:0]          b_done;
  logic [NUM_S-1:0]          b_done_next;
  logic [NUM_S-1:0]          bank_awready;
  logic [NUM_S-1:0]          bank_wready;
  logic [NUM_S-1:0]          bank_bvalid;
  logic [`STRIPE_ADDR_W-1:0] aw_addr;
  logic [`STRIPE_ID_W-1:0]   aw_id;
  logic [7:0]                aw_len;
  logic [2:0]                aw_size;
  logic [1:0]                aw_burst;
  logic [S_W-1:0]            idx;
  logic [7:0]                stripes_todo;

  assign aw_hs = s_awvalid && s_awready;
  assign w_hs  = s_wvalid && s_wready;
  assign b_hs  = s_bvalid && s_bready;
  assign aw_u  = s_awaddr;

  // --------------------------------------------------------------------------
  // AW fan-out and beat tracking
  // --------------------------------------------------------------------------

  // every bank sees the same burst with the bank select bits removed
  // the word field slides down into the place of the select bits
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr  <= {{`STRIPE_SEL_W{1'b0}}, aw_u.f.word, {`STRIPE_OFF_W{1'b0}}};
      aw_id    <= s_awid;
      aw_len   <= s_awlen >> S_W;
      aw_size  <= s_awsize;
      aw_burst <= s_awburst;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_awready    <= 1'b1;
      aw_valid     <= '0;
      aw_done      <= '0;
      idx          <= '0;
      stripes_todo <= '0;
    end else begin
      if (aw_hs) begin
        s_awready    <= 1'b0;
        aw_valid     <= '1;
        aw_done      <= '0;
        idx          <= '0;
        stripes_todo <= s_awlen >> S_W;
      end else begin
        // each bank keeps its awvalid up until it takes the address
        aw_valid <= aw_valid & ~bank_awready;
        aw_done  <= aw_done | (aw_valid & bank_awready);
        if (w_hs) begin
          // idx wraps on its own since NUM_S is a power of two
          idx <= idx + 1'b1;
          if (idx == '1 && stripes_todo != '0) begin
            stripes_todo <= stripes_todo - 1'b1;
          end
        end
      end
      // the next burst may start once the joined response is taken
      if (b_hs) begin
        s_awready <= 1'b1;
        aw_done   <= '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // per bank link wiring
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < NUM_S; i++) begin : g_link
    assign m[i].awvalid    = aw_valid[i];
    assign m[i].awaddr     = aw_addr;
    assign m[i].awid       = aw_id;
    assign m[i].awlen      = aw_len;
    assign m[i].awsize     = aw_size;
    assign m[i].awburst    = aw_burst;
    assign bank_awready[i] = m[i].awready;
    // a beat goes to the bank its index selects, never before that bank has
    // its address
    assign m[i].wvalid     = s_wvalid && aw_done[i] && (idx == S_W'(i));
    assign m[i].wdata      = s_wdata;
    assign m[i].wstrb      = s_wstrb;
    assign m[i].wlast      = (stripes_todo == '0);
    assign bank_wready[i]  = m[i].wready;
    assign bank_bvalid[i]  = m[i].bvalid;
    // one response per bank and burst so a bank is released once it answered
    assign m[i].bready     = !b_done[i];
  end

  assign s_wready = bank_wready[idx] && aw_done[idx];

  // --------------------------------------------------------------------------
  // B join
  // --------------------------------------------------------------------------

  always_comb begin
    b_done_next = b_done | bank_bvalid;
    if (b_hs) begin
      b_done_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done   <= '0;
      s_bvalid <= 1'b0;
    end else begin
      b_done   <= b_done_next;
      s_bvalid <= &b_done_next;
    end
  end

  // all banks saw the same burst so bank 0 speaks for the id and the response
  always_ff @(posedge clk) begin
    if (bank_bvalid[0] && !b_done[0]) begin
      s_bid   <= m[0].bid;
      s_bresp <= m[0].bresp;
    end
  end

  // --------------------------------------------------------------------------
  // usage checks
  // --------------------------------------------------------------------------

  a_aw_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    s_awvalid |-> aw_u.flat[`STRIPE_SEL_W+`STRIPE_OFF_W-1:0] == '0);

  a_aw_len_stripes : assert property (@(posedge clk) disable iff (!rst_n)
    s_awvalid |-> ((9'(s_awlen) + 9'd1) % NUM_S) == 0);

  // a new burst only fans out once no bank still holds a response and every
  // bank is free to take its address again
  a_no_aw_during_b : assert property (@(posedge clk) disable iff (!rst_n)
    aw_hs |-> (&bank_awready) && (bank_bvalid == '0));

  // the manager's wlast must land where the stripe counter puts the end
  a_wlast_counter : assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |-> s_wlast == ((stripes_todo == '0) && (idx == '1)));

endmodule

// File: src/axi_wr_bank.sv
`include "stripe_consts.svh"

// one storage bank behind the striper with an AXI write side and a plain
// registered read port
module axi_wr_bank (
  input  logic                       clk,
  input  logic                       rst_n,
  stripe_axi_if.sub                  s,
  input  logic [`STRIPE_BANK_AW-1:0] rd_addr,
  output logic [`STRIPE_DATA_W-1:0]  rd_data
);

  localparam int WPTR_W = `STRIPE_ADDR_W - `STRIPE_OFF_W;

  logic                     aw_rdy;
  logic                     w_rdy;
  logic                     b_vld;
  logic                     w_hs;
  logic                     ovf;
  logic                     err;
  logic [WPTR_W-1:0]        wptr;
  logic [7:0]               beat;
  logic [7:0]               len;
  logic [`STRIPE_ID_W-1:0]   id_q;
  stripe_pkg::stripe_resp_e resp_q;
  logic [`STRIPE_DATA_W-1:0] mem [`STRIPE_BANK_WORDS];

  assign s.awready = aw_rdy;
  assign s.wready  = w_rdy;
  assign s.bvalid  = b_vld;
  assign s.bid     = id_q;
  assign s.bresp   = resp_q;

  assign w_hs = s.wvalid && w_rdy;
  // a word past the bank depth is dropped and marks the burst as failed
  assign ovf  = wptr >= WPTR_W'(`STRIPE_BANK_WORDS);

  // one burst at a time, so wready doubles as the in-burst flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_rdy <= 1'b1;
      w_rdy  <= 1'b0;
      b_vld  <= 1'b0;
    end else begin
      if (s.awvalid && aw_rdy) begin
        aw_rdy <= 1'b0;
        w_rdy  <= 1'b1;
      end
      if (w_hs && s.wlast) begin
        w_rdy <= 1'b0;
        b_vld <= 1'b1;
      end
      if (b_vld && s.bready) begin
        b_vld  <= 1'b0;
        aw_rdy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s.awvalid && aw_rdy) begin
      wptr <= s.awaddr[`STRIPE_ADDR_W-1:`STRIPE_OFF_W];
      len  <= s.awlen;
      beat <= '0;
      id_q <= s.awid;
      err  <= 1'b0;
    end else if (w_hs) begin
      wptr <= wptr + 1'b1;
      beat <= beat + 1'b1;
      err  <= err || ovf;
      // the final beat settles the response for the whole burst
      if (s.wlast) begin
        if (err || ovf) begin
          resp_q <= stripe_pkg::SLVERR;
        end else begin
          resp_q <= stripe_pkg::OKAY;
        end
      end
    end
  end

  // byte lanes are written under wstrb and the read data follows rd_addr by
  // one cycle
  always_ff @(posedge clk) begin
    if (w_hs && !ovf) begin
      for (int b = 0; b < `STRIPE_STRB_W; b++) begin
        if (s.wstrb[b]) begin
          mem[wptr[`STRIPE_BANK_AW-1:0]][8*b +: 8] <= s.wdata[8*b +: 8];
        end
      end
    end
    rd_data <= mem[rd_addr];
  end

  a_w_in_burst : assert property (@(posedge clk) disable iff (!rst_n)
    s.wvalid |-> w_rdy);

  a_wlast_final : assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |-> s.wlast == (beat == len));

endmodule

// File: src/stripe_axi_if.sv
`include "stripe_consts.svh"

// one AXI write link between the striper and a bank
// the read channels are not part of this design
interface stripe_axi_if;

  // write address channel
  logic                     awvalid;
  logic [`STRIPE_ADDR_W-1:0] awaddr;
  logic [`STRIPE_ID_W-1:0]   awid;
  logic [7:0]               awlen;
  logic [2:0]               awsize;
  logic [1:0]               awburst;
  logic                     awready;

  // write data channel
  logic                     wvalid;
  logic [`STRIPE_DATA_W-1:0] wdata;
  logic [`STRIPE_STRB_W-1:0] wstrb;
  logic                     wlast;
  logic                     wready;

  // write response channel
  logic                     bvalid;
  logic [`STRIPE_ID_W-1:0]   bid;
  stripe_pkg::stripe_resp_e bresp;
  logic                     bready;

  // the side that issues bursts
  modport mgr (
    output awvalid, awaddr, awid, awlen, awsize, awburst,
    input  awready,
    output wvalid, wdata, wstrb, wlast,
    input  wready,
    input  bvalid, bid, bresp,
    output bready
  );

  // the side that stores them
  modport sub (
    input  awvalid, awaddr, awid, awlen, awsize, awburst,
    output awready,
    input  wvalid, wdata, wstrb, wlast,
    output wready,
    output bvalid, bid, bresp,
    input  bready
  );

endinterface

// File: src/stripe_pkg.sv
`include "stripe_consts.svh"

package stripe_pkg;

  // ------------------------------------------------------------------------
  // address layout
  // ------------------------------------------------------------------------

  // a manager byte address splits into the word inside a bank, the bank
  // select and the byte offset inside the word
  // manager word w lives in bank (w mod NUM_S) at local word (w / NUM_S)
  typedef struct packed {
    logic [`STRIPE_ADDR_W-`STRIPE_SEL_W-`STRIPE_OFF_W-1:0] word;
    logic [`STRIPE_SEL_W-1:0]                              sel;
    logic [`STRIPE_OFF_W-1:0]                              off;
  } stripe_addr_s;

  // the same address seen flat for alignment and length handling, or
  // through its fields for the bank split
  typedef union packed {
    logic [`STRIPE_ADDR_W-1:0] flat;
    stripe_addr_s              f;
  } stripe_addr_u;

  // ------------------------------------------------------------------------
  // write response
  // ------------------------------------------------------------------------

  // only the two codes the banks can return
  typedef enum logic [1:0] {
    OKAY   = `STRIPE_RESP_OKAY,
    SLVERR = `STRIPE_RESP_SLVERR
  } stripe_resp_e;

endpackage

// File: src/stripe_consts.svh
`ifndef STRIPE_CONSTS_SVH
`define STRIPE_CONSTS_SVH

// number of banks behind the striper, kept a power of two
`define STRIPE_NUM_S 4

// manager side byte address and data path
`define STRIPE_ADDR_W 12
`define STRIPE_DATA_W 32
`define STRIPE_STRB_W 4
`define STRIPE_ID_W 4

// bank select and byte offset field widths of a manager address
`define STRIPE_SEL_W 2
`define STRIPE_OFF_W 2

// storage depth of one bank in words and its index width
`define STRIPE_BANK_WORDS 64
`define STRIPE_BANK_AW 6

`define STRIPE_RESP_OKAY 2'd0
`define STRIPE_RESP_SLVERR 2'd2

`endif
